/* logic/tlb_pkg.sv */
// Translation engine package with widths, vector types, APB register map and walk states
package tlb_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	localparam int VADDR_BITS = 32;
	localparam int PADDR_BITS = 32;
	localparam int LEN_BITS = 16;
	localparam int PID_BITS = 4;
	localparam int DEST_BITS = 4;

	// Page offsets, 4 KiB small and 64 KiB large
	localparam int PG_S_BITS = 12;
	localparam int PG_L_BITS = 16;

	// ----------------------------------------
	// Vector types
	// ----------------------------------------
	typedef logic [VADDR_BITS-1:0] vaddr_t;
	typedef logic [PADDR_BITS-1:0] paddr_t;
	typedef logic [LEN_BITS-1:0] len_t;
	typedef logic [PID_BITS-1:0] pid_t;
	typedef logic [DEST_BITS-1:0] dest_t;

	// APB side
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// ----------------------------------------
	// Register offsets
	// ----------------------------------------
	localparam apb_addr_t REG_FILL_VADDR = 8'h00;
	localparam apb_addr_t REG_FILL_PADDR = 8'h04;
	// Commits the staged entry
	localparam apb_addr_t REG_FILL_CMD = 8'h08;
	localparam apb_addr_t REG_FAULT_VADDR = 8'h0C;
	localparam apb_addr_t REG_FAULT_INFO = 8'h10;
	localparam apb_addr_t REG_RESTART = 8'h14;

	// Walk states
	typedef enum logic [3:0] {
		IDLE, MUTEX, WAIT, CHECK,
		HIT_LARGE, HIT_SMALL, CALC_LARGE, CALC_SMALL,
		SEND, MISS
	} walk_state_t;

endpackage

/* logic/tlb_ifs.sv */
// Lookup, fill and fault bundles between translation blocks

// Engine asks, table answers two cycles later
interface tlb_lookup_if;
	logic valid;
	tlb_pkg::vaddr_t vaddr;
	tlb_pkg::pid_t pid;
	logic hit;
	// Page base, offset bits zero
	tlb_pkg::paddr_t ppage;

	modport engine (output valid, vaddr, pid, input hit, ppage);
	modport tbl (input valid, vaddr, pid, output hit, ppage);
endinterface

// Entry write from the register block into one of the tables
interface tlb_fill_if;
	logic fill_valid;
	logic fill_large;
	tlb_pkg::vaddr_t fill_vaddr;
	tlb_pkg::pid_t fill_pid;
	tlb_pkg::paddr_t fill_ppage;

	modport source (output fill_valid, fill_large, fill_vaddr, fill_pid, fill_ppage);
	modport sink (input fill_valid, fill_large, fill_vaddr, fill_pid, fill_ppage);
endinterface

// Page fault report and restart handshake
interface tlb_fault_if;
	logic fault_valid;
	tlb_pkg::vaddr_t fault_vaddr;
	tlb_pkg::len_t fault_len;
	tlb_pkg::pid_t fault_pid;
	logic restart;

	modport engine (output fault_valid, fault_vaddr, fault_len, fault_pid, input restart);
	modport register (input fault_valid, fault_vaddr, fault_len, fault_pid, output restart);
endinterface

/* logic/tlb_apb_regs.sv */
// APB register block staging table fills, holding page faults and issuing restart
module tlb_apb_regs (
	input  logic aclk,
	input  logic aresetn,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  tlb_pkg::apb_addr_t paddr,
	input  tlb_pkg::apb_data_t pwdata,
	output tlb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic pfault_irq,
	tlb_fill_if.source fill,
	tlb_fault_if.register fault
);

// Command word, pid in the low bits
localparam int CMD_LARGE_BIT = 8;

logic access;
logic wr_en;
logic known;

// Staged entry
tlb_pkg::vaddr_t fill_vaddr_q;
tlb_pkg::paddr_t fill_paddr_q;
tlb_pkg::pid_t fill_pid_q;
logic fill_large_q;
logic fill_valid_q;

// Fault record
tlb_pkg::vaddr_t fault_vaddr_q;
tlb_pkg::len_t fault_len_q;
tlb_pkg::pid_t fault_pid_q;
logic pending_q;
logic restart_q;

// ----------------------------------------
// Access decode
// ----------------------------------------
assign access = psel && penable;
assign wr_en = access && pwrite;
// Zero wait states
assign pready = 1'b1;

always_comb begin
	known = 1'b1;
	prdata = '0;
	case (paddr)
		tlb_pkg::REG_FILL_VADDR: prdata = fill_vaddr_q;
		tlb_pkg::REG_FILL_PADDR: prdata = fill_paddr_q;
		// Last command readback
		tlb_pkg::REG_FILL_CMD: prdata = tlb_pkg::apb_data_t'({fill_large_q, 4'b0, fill_pid_q});
		tlb_pkg::REG_FAULT_VADDR: prdata = fault_vaddr_q;
		// Pending in bit 31, pid above len
		tlb_pkg::REG_FAULT_INFO: begin
			prdata = tlb_pkg::apb_data_t'({fault_pid_q, fault_len_q});
			prdata[31] = pending_q;
		end
		tlb_pkg::REG_RESTART: prdata = '0;
		default: known = 1'b0;
	endcase
end

// Error only in the access phase
assign pslverr = access && !known;

// ----------------------------------------
// Fill staging
// ----------------------------------------
always_ff @(posedge aclk) begin
	if (wr_en && paddr == tlb_pkg::REG_FILL_VADDR) begin
		fill_vaddr_q <= pwdata;
	end
	if (wr_en && paddr == tlb_pkg::REG_FILL_PADDR) begin
		fill_paddr_q <= pwdata;
	end
	if (wr_en && paddr == tlb_pkg::REG_FILL_CMD) begin
		fill_pid_q <= pwdata[tlb_pkg::PID_BITS-1:0];
		fill_large_q <= pwdata[CMD_LARGE_BIT];
	end
end

// Commit pulse one cycle after the command write
always_ff @(posedge aclk) begin
	if (!aresetn) begin
		fill_valid_q <= 1'b0;
	end else begin
		fill_valid_q <= wr_en && paddr == tlb_pkg::REG_FILL_CMD;
	end
end

assign fill.fill_valid = fill_valid_q;
assign fill.fill_large = fill_large_q;
assign fill.fill_vaddr = fill_vaddr_q;
assign fill.fill_pid = fill_pid_q;
assign fill.fill_ppage = fill_paddr_q;

// ----------------------------------------
// Fault and restart
// ----------------------------------------
always_ff @(posedge aclk) begin
	if (fault.fault_valid) begin
		fault_vaddr_q <= fault.fault_vaddr;
		fault_len_q <= fault.fault_len;
		fault_pid_q <= fault.fault_pid;
	end
end

always_ff @(posedge aclk) begin
	if (!aresetn) begin
		pending_q <= 1'b0;
		restart_q <= 1'b0;
	end else begin
		restart_q <= wr_en && paddr == tlb_pkg::REG_RESTART;
		// New fault wins over a restart in the same cycle
		if (fault.fault_valid) begin
			pending_q <= 1'b1;
		end else if (wr_en && paddr == tlb_pkg::REG_RESTART) begin
			pending_q <= 1'b0;
		end
	end
end

assign fault.restart = restart_q;
assign pfault_irq = pending_q;

endmodule

/* logic/tlb_table.sv */
// Direct-mapped translation table with a two-stage registered lookup
module tlb_table #(
	parameter int ORDER = 4,
	parameter int PG_BITS = 12,
	parameter bit LARGE = 1'b0
) (
	input logic aclk,
	input logic aresetn,
	tlb_fill_if.sink fill,
	tlb_lookup_if.tbl lookup
);

localparam int ENTRIES = 1 << ORDER;
// Tag sits above index, index above page offset
localparam int TAG_BITS = tlb_pkg::VADDR_BITS - ORDER - PG_BITS;
localparam int PPN_BITS = tlb_pkg::PADDR_BITS - PG_BITS;

typedef logic [ORDER-1:0] idx_t;
typedef logic [TAG_BITS-1:0] tag_t;
typedef logic [PPN_BITS-1:0] ppn_t;

// ----------------------------------------
// Entry storage
// ----------------------------------------
logic [ENTRIES-1:0] entry_valid;
tag_t tag_mem [ENTRIES];
tlb_pkg::pid_t pid_mem [ENTRIES];
ppn_t ppn_mem [ENTRIES];

idx_t wr_idx;
idx_t rd_idx;
logic wr_en;

// Read stage
logic rd_act;
logic rd_valid;
tag_t rd_tag;
tlb_pkg::pid_t rd_pid;
ppn_t rd_ppn;
tag_t cmp_tag;
tlb_pkg::pid_t cmp_pid;

assign wr_idx = fill.fill_vaddr[PG_BITS +: ORDER];
assign rd_idx = lookup.vaddr[PG_BITS +: ORDER];
// Only fills of this page size land here
assign wr_en = fill.fill_valid && (fill.fill_large == LARGE);

always_ff @(posedge aclk) begin
	if (!aresetn) begin
		entry_valid <= '0;
	end else if (wr_en) begin
		entry_valid[wr_idx] <= 1'b1;
	end
end

always_ff @(posedge aclk) begin
	if (wr_en) begin
		tag_mem[wr_idx] <= fill.fill_vaddr[tlb_pkg::VADDR_BITS-1 -: TAG_BITS];
		pid_mem[wr_idx] <= fill.fill_pid;
		ppn_mem[wr_idx] <= fill.fill_ppage[tlb_pkg::PADDR_BITS-1 -: PPN_BITS];
	end
end

// ----------------------------------------
// Stage 1, entry read
// ----------------------------------------
always_ff @(posedge aclk) begin
	if (!aresetn) begin
		rd_act <= 1'b0;
	end else begin
		rd_act <= lookup.valid;
	end
end

always_ff @(posedge aclk) begin
	if (lookup.valid) begin
		rd_valid <= entry_valid[rd_idx];
		rd_tag <= tag_mem[rd_idx];
		rd_pid <= pid_mem[rd_idx];
		rd_ppn <= ppn_mem[rd_idx];
		// Request side kept for the compare
		cmp_tag <= lookup.vaddr[tlb_pkg::VADDR_BITS-1 -: TAG_BITS];
		cmp_pid <= lookup.pid;
	end
end

// ----------------------------------------
// Stage 2, tag and pid compare
// ----------------------------------------
// Result held until the next lookup
always_ff @(posedge aclk) begin
	if (!aresetn) begin
		lookup.hit <= 1'b0;
	end else if (rd_act) begin
		lookup.hit <= rd_valid && (rd_tag == cmp_tag) && (rd_pid == cmp_pid);
	end
end

always_ff @(posedge aclk) begin
	if (rd_act) begin
		lookup.ppage <= {rd_ppn, {PG_BITS{1'b0}}};
	end
end

endmodule

/* logic/tlb_walk_fsm.sv */
// Write-side walk FSM taking the mutex, looking up both tables and issuing page pieces
module tlb_walk_fsm #(
	parameter bit RDWR = 1'b1,
	parameter int TLB_L_ORDER = 4,
	parameter int TLB_S_ORDER = 4
) (
	input  logic aclk,
	input  logic aresetn,
	input  logic req_valid,
	input  tlb_pkg::vaddr_t req_vaddr,
	input  tlb_pkg::len_t req_len,
	input  tlb_pkg::pid_t req_pid,
	input  tlb_pkg::dest_t req_dest,
	input  logic req_ctl,
	output logic req_ready,
	tlb_lookup_if.engine lookup_l,
	tlb_lookup_if.engine lookup_s,
	tlb_fault_if.engine fault,
	output logic dma_valid,
	output tlb_pkg::paddr_t dma_paddr,
	output tlb_pkg::len_t dma_len,
	output tlb_pkg::pid_t dma_pid,
	output tlb_pkg::dest_t dma_dest,
	output logic dma_ctl,
	input  logic dma_ready,
	output logic lock,
	output logic unlock,
	input  logic mutex_owner,
	input  logic mutex_busy
);

// Room in a page can be a full page, one bit wider than len
localparam int ROOM_BITS = tlb_pkg::LEN_BITS + 1;
typedef logic [ROOM_BITS-1:0] room_t;

localparam room_t PG_L_SIZE = room_t'(1 << tlb_pkg::PG_L_BITS);
localparam room_t PG_S_SIZE = room_t'(1 << tlb_pkg::PG_S_BITS);
localparam tlb_pkg::paddr_t OFFS_L_MASK = tlb_pkg::paddr_t'((1 << tlb_pkg::PG_L_BITS) - 1);
localparam tlb_pkg::paddr_t OFFS_S_MASK = tlb_pkg::paddr_t'((1 << tlb_pkg::PG_S_BITS) - 1);

// Both tables need tag bits above the index
generate
	if (tlb_pkg::VADDR_BITS <= TLB_L_ORDER + tlb_pkg::PG_L_BITS ||
		tlb_pkg::VADDR_BITS <= TLB_S_ORDER + tlb_pkg::PG_S_BITS) begin : g_order
		$error("Table order leaves no tag bits");
	end
endgenerate

tlb_pkg::walk_state_t state_q;
tlb_pkg::walk_state_t state_d;

// Request in flight
tlb_pkg::vaddr_t vaddr_q;
tlb_pkg::len_t len_q;
tlb_pkg::pid_t pid_q;
tlb_pkg::dest_t dest_q;
logic ctl_q;

// Current piece
tlb_pkg::paddr_t ppage_q;
room_t room_q;
tlb_pkg::paddr_t paddr_q;
tlb_pkg::len_t plen_q;

logic unlock_q;
logic fault_q;
logic grant;
logic any_hit;

assign grant = (mutex_owner == RDWR) && !mutex_busy;
assign any_hit = lookup_l.hit || lookup_s.hit;

// ----------------------------------------
// Next state
// ----------------------------------------
always_comb begin
	state_d = state_q;
	case (state_q)
		tlb_pkg::IDLE: begin
			// Zero length taken and dropped
			if (req_valid && req_len != '0) begin
				state_d = tlb_pkg::MUTEX;
			end
		end
		tlb_pkg::MUTEX: begin
			if (grant) begin
				state_d = tlb_pkg::WAIT;
			end
		end
		// Table read stage
		tlb_pkg::WAIT: state_d = tlb_pkg::CHECK;
		tlb_pkg::CHECK: begin
			// Large page first
			if (lookup_l.hit) begin
				state_d = tlb_pkg::HIT_LARGE;
			end else if (lookup_s.hit) begin
				state_d = tlb_pkg::HIT_SMALL;
			end else begin
				state_d = tlb_pkg::MISS;
			end
		end
		tlb_pkg::HIT_LARGE: state_d = tlb_pkg::CALC_LARGE;
		tlb_pkg::HIT_SMALL: state_d = tlb_pkg::CALC_SMALL;
		tlb_pkg::CALC_LARGE, tlb_pkg::CALC_SMALL: state_d = tlb_pkg::SEND;
		tlb_pkg::SEND: begin
			// Bytes left means another lookup
			if (dma_ready) begin
				state_d = (len_q != '0) ? tlb_pkg::MUTEX : tlb_pkg::IDLE;
			end
		end
		tlb_pkg::MISS: begin
			if (fault.restart) begin
				state_d = tlb_pkg::MUTEX;
			end
		end
		default: state_d = tlb_pkg::IDLE;
	endcase
end

always_ff @(posedge aclk) begin
	if (!aresetn) begin
		state_q <= tlb_pkg::IDLE;
		unlock_q <= 1'b0;
		fault_q <= 1'b0;
	end else begin
		state_q <= state_d;
		unlock_q <= (state_q == tlb_pkg::CHECK) && any_hit;
		fault_q <= (state_q == tlb_pkg::CHECK) && !any_hit;
	end
end

// ----------------------------------------
// Datapath
// ----------------------------------------
always_ff @(posedge aclk) begin
	case (state_q)
		tlb_pkg::IDLE: begin
			if (req_valid) begin
				vaddr_q <= req_vaddr;
				len_q <= req_len;
				pid_q <= req_pid;
				dest_q <= req_dest;
				ctl_q <= req_ctl;
			end
		end
		// Page base and room up to the boundary
		tlb_pkg::HIT_LARGE: begin
			ppage_q <= lookup_l.ppage;
			room_q <= PG_L_SIZE - room_t'(vaddr_q[tlb_pkg::PG_L_BITS-1:0]);
		end
		tlb_pkg::HIT_SMALL: begin
			ppage_q <= lookup_s.ppage;
			room_q <= PG_S_SIZE - room_t'(vaddr_q[tlb_pkg::PG_S_BITS-1:0]);
		end
		tlb_pkg::CALC_LARGE, tlb_pkg::CALC_SMALL: begin
			if (state_q == tlb_pkg::CALC_LARGE) begin
				paddr_q <= ppage_q | (vaddr_q & OFFS_L_MASK);
			end else begin
				paddr_q <= ppage_q | (vaddr_q & OFFS_S_MASK);
			end
			// Piece is the lesser of remaining and room
			if (room_t'(len_q) > room_q) begin
				plen_q <= room_q[tlb_pkg::LEN_BITS-1:0];
				len_q <= len_q - room_q[tlb_pkg::LEN_BITS-1:0];
				vaddr_q <= vaddr_q + tlb_pkg::vaddr_t'(room_q);
			end else begin
				plen_q <= len_q;
				len_q <= '0;
			end
		end
		default: ;
	endcase
end

// ----------------------------------------
// Outputs
// ----------------------------------------
assign req_ready = (state_q == tlb_pkg::IDLE);
assign lock = (state_q == tlb_pkg::MUTEX);
assign unlock = unlock_q;

// Lookup starts on grant
assign lookup_l.valid = (state_q == tlb_pkg::MUTEX) && grant;
assign lookup_l.vaddr = vaddr_q;
assign lookup_l.pid = pid_q;
assign lookup_s.valid = (state_q == tlb_pkg::MUTEX) && grant;
assign lookup_s.vaddr = vaddr_q;
assign lookup_s.pid = pid_q;

// Fields stay put while waiting in MISS
assign fault.fault_valid = fault_q;
assign fault.fault_vaddr = vaddr_q;
assign fault.fault_len = len_q;
assign fault.fault_pid = pid_q;

assign dma_valid = (state_q == tlb_pkg::SEND);
assign dma_paddr = paddr_q;
assign dma_len = plen_q;
assign dma_pid = pid_q;
assign dma_dest = dest_q;
// Last piece only
assign dma_ctl = ctl_q && (len_q == '0);

endmodule

/* logic/tlb_translate_top.sv */
// Write-side address translation top with APB registers, two tables and walk FSM
module tlb_translate_top #(
	parameter int TLB_L_ORDER = 4,
	parameter int TLB_S_ORDER = 4,
	parameter bit RDWR = 1'b1
) (
	input  logic aclk,
	input  logic aresetn,
	// Request
	input  logic req_valid,
	input  tlb_pkg::vaddr_t req_vaddr,
	input  tlb_pkg::len_t req_len,
	input  tlb_pkg::pid_t req_pid,
	input  tlb_pkg::dest_t req_dest,
	input  logic req_ctl,
	output logic req_ready,
	// Host DMA
	output logic dma_valid,
	output tlb_pkg::paddr_t dma_paddr,
	output tlb_pkg::len_t dma_len,
	output tlb_pkg::pid_t dma_pid,
	output tlb_pkg::dest_t dma_dest,
	output logic dma_ctl,
	input  logic dma_ready,
	// Mutex
	output logic lock,
	output logic unlock,
	input  logic mutex_owner,
	input  logic mutex_busy,
	// APB
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  tlb_pkg::apb_addr_t paddr,
	input  tlb_pkg::apb_data_t pwdata,
	output tlb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic pfault_irq
);

tlb_lookup_if lookup_l ();
tlb_lookup_if lookup_s ();
tlb_fill_if fill ();
tlb_fault_if fault ();

// ----------------------------------------
// Register port
// ----------------------------------------
tlb_apb_regs regs_i (
	.aclk(aclk), .aresetn(aresetn),
	.psel(psel), .penable(penable), .pwrite(pwrite),
	.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
	.pready(pready), .pslverr(pslverr), .pfault_irq(pfault_irq),
	.fill(fill), .fault(fault)
);

// Large and small page tables
tlb_table #(.ORDER(TLB_L_ORDER), .PG_BITS(tlb_pkg::PG_L_BITS), .LARGE(1'b1)) table_l_i (
	.aclk(aclk), .aresetn(aresetn), .fill(fill), .lookup(lookup_l)
);

tlb_table #(.ORDER(TLB_S_ORDER), .PG_BITS(tlb_pkg::PG_S_BITS), .LARGE(1'b0)) table_s_i (
	.aclk(aclk), .aresetn(aresetn), .fill(fill), .lookup(lookup_s)
);

// Walk FSM
tlb_walk_fsm #(.RDWR(RDWR), .TLB_L_ORDER(TLB_L_ORDER), .TLB_S_ORDER(TLB_S_ORDER)) walk_i (
	.aclk(aclk), .aresetn(aresetn),
	.req_valid(req_valid), .req_vaddr(req_vaddr), .req_len(req_len),
	.req_pid(req_pid), .req_dest(req_dest), .req_ctl(req_ctl), .req_ready(req_ready),
	.lookup_l(lookup_l), .lookup_s(lookup_s), .fault(fault),
	.dma_valid(dma_valid), .dma_paddr(dma_paddr), .dma_len(dma_len),
	.dma_pid(dma_pid), .dma_dest(dma_dest), .dma_ctl(dma_ctl), .dma_ready(dma_ready),
	.lock(lock), .unlock(unlock),
	.mutex_owner(mutex_owner), .mutex_busy(mutex_busy)
);

endmodule

/* test/tb_clock.sv */
// Testbench clock and reset source, period 20 with reset held for 5 cycles
module tb_clock (
	output logic aclk,
	output logic aresetn
);

initial begin
	aclk = 1'b0;
	forever begin
		#10 aclk = ~aclk;
	end
end

// Reset released on a falling edge
initial begin
	aresetn = 1'b0;
	repeat (5) @(posedge aclk);
	@(negedge aclk);
	aresetn = 1'b1;
end

endmodule

/* test/tb_checker.sv */
// Testbench checker comparing DMA pieces and register values against expected data
module tb_checker (
	input logic aclk,
	input logic dma_valid,
	input logic dma_ready,
	input logic [31:0] dma_paddr,
	input logic [15:0] dma_len,
	input logic [3:0] dma_pid,
	input logic [3:0] dma_dest,
	input logic dma_ctl,
	input logic unlock
);

// Pieces packed as paddr, len, pid, dest and ctl
logic [56:0] expected_q[$];
string test_name = "none";
int test_errors = 0;
int total_errors = 0;
int tests_run = 0;
int tests_failed = 0;

// Back-pressure and mutex tracking
logic stalled = 1'b0;
logic [56:0] stalled_piece;
int unlocks = 0;
int pieces_seen = 0;

task automatic begin_test(input string name);
	test_name = name;
	test_errors = 0;
endtask

task automatic end_test();
	tests_run++;
	if (test_errors == 0) begin
		$display("Pass %s", test_name);
	end else begin
		tests_failed++;
		$display("Test %s finished with %0d errors", test_name, test_errors);
	end
endtask

task automatic expect_piece(input logic [31:0] paddr, input logic [15:0] len,
		input logic [3:0] pid, input logic [3:0] dest, input logic ctl);
	expected_q.push_back({paddr, len, pid, dest, ctl});
endtask

function automatic int pieces_left();
	return expected_q.size();
endfunction

function automatic int error_count();
	return total_errors;
endfunction

task automatic report_error(input string msg);
	test_errors++;
	total_errors++;
	$display("%s", msg);
endtask

task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
	if (expected !== actual) begin
		report_error($sformatf("Fail %s %s expected %h actual %h",
			test_name, what, expected, actual));
	end
endtask

task automatic print_counts();
	$display("Tests run %0d, tests failed %0d, errors %0d",
		tests_run, tests_failed, total_errors);
endtask

// ----------------------------------------
// DMA monitor
// ----------------------------------------
// One piece per accepted handshake and one unlock pulse per hit
always @(posedge aclk) begin
	logic [56:0] expected;
	logic [56:0] actual;
	actual = {dma_paddr, dma_len, dma_pid, dma_dest, dma_ctl};
	if (unlock === 1'b1) begin
		unlocks++;
	end
	// Stalled piece stays valid and unchanged
	if (stalled && dma_valid !== 1'b1) begin
		report_error($sformatf("Test %s dropped dma_valid while dma_ready was low",
			test_name));
	end else if (stalled && actual !== stalled_piece) begin
		report_error($sformatf("Fail %s stalled piece expected %h actual %h",
			test_name, stalled_piece, actual));
	end
	stalled = (dma_valid === 1'b1 && dma_ready !== 1'b1);
	stalled_piece = actual;
	if (dma_valid === 1'b1 && dma_ready === 1'b1) begin
		pieces_seen++;
		if (expected_q.size() == 0) begin
			report_error($sformatf("Test %s saw a DMA piece that was not expected, %h",
				test_name, actual));
		end else begin
			expected = expected_q.pop_front();
			if (expected !== actual) begin
				report_error($sformatf("Fail %s dma piece expected %h actual %h",
					test_name, expected, actual));
			end
		end
		// Every piece comes from one table hit
		if (unlocks != pieces_seen) begin
			report_error($sformatf("Fail %s unlock pulses expected %0d actual %0d",
				test_name, pieces_seen, unlocks));
			unlocks = pieces_seen;
		end
	end
end

endmodule

/* test/tb_top.sv */
// Translation engine testbench top driving records from the input file into the DUT
module tb_top;

localparam int TIMEOUT = 2000;

logic aclk;
logic aresetn;
logic req_valid;
logic [31:0] req_vaddr;
logic [15:0] req_len;
logic [3:0] req_pid;
logic [3:0] req_dest;
logic req_ctl;
logic req_ready;
logic dma_valid;
logic [31:0] dma_paddr;
logic [15:0] dma_len;
logic [3:0] dma_pid;
logic [3:0] dma_dest;
logic dma_ctl;
logic dma_ready;
logic lock;
logic unlock;
logic mutex_owner;
logic mutex_busy;
logic psel;
logic penable;
logic pwrite;
logic [7:0] paddr;
logic [31:0] pwdata;
logic [31:0] prdata;
logic pready;
logic pslverr;
logic pfault_irq;

integer seed;
logic stall_en;
logic lock_q;

tb_clock clock_i (.aclk(aclk), .aresetn(aresetn));

tlb_translate_top #(.TLB_L_ORDER(4), .TLB_S_ORDER(4), .RDWR(1'b1)) tlb_translate_top_i (
	.aclk(aclk), .aresetn(aresetn),
	.req_valid(req_valid), .req_vaddr(req_vaddr), .req_len(req_len),
	.req_pid(req_pid), .req_dest(req_dest), .req_ctl(req_ctl), .req_ready(req_ready),
	.dma_valid(dma_valid), .dma_paddr(dma_paddr), .dma_len(dma_len),
	.dma_pid(dma_pid), .dma_dest(dma_dest), .dma_ctl(dma_ctl), .dma_ready(dma_ready),
	.lock(lock), .unlock(unlock), .mutex_owner(mutex_owner), .mutex_busy(mutex_busy),
	.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
	.prdata(prdata), .pready(pready), .pslverr(pslverr), .pfault_irq(pfault_irq)
);

tb_checker checker_i (
	.aclk(aclk), .dma_valid(dma_valid), .dma_ready(dma_ready),
	.dma_paddr(dma_paddr), .dma_len(dma_len), .dma_pid(dma_pid),
	.dma_dest(dma_dest), .dma_ctl(dma_ctl), .unlock(unlock)
);

// ----------------------------------------
// Mutex and DMA ready models
// ----------------------------------------
// Grant one cycle after lock rises
always @(negedge aclk) begin
	if (!aresetn) begin
		mutex_busy = 1'b1;
		lock_q = 1'b0;
	end else begin
		mutex_busy = !(lock && lock_q);
		lock_q = lock;
	end
end

// Random back-pressure about one cycle in four
always @(negedge aclk) begin
	if (stall_en) begin
		dma_ready = (($random(seed) & 3) != 0);
	end else begin
		dma_ready = 1'b1;
	end
end

task automatic stop_on_timeout(input string what);
	$display("Timeout while waiting for %s", what);
	checker_i.print_counts();
	$display("Done: errors found");
	$finish;
endtask

// ----------------------------------------
// APB accesses with zero wait states
// ----------------------------------------
task automatic apb_access(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
	int t;
	t = 0;
	@(negedge aclk);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = write;
	paddr = addr;
	pwdata = wdata;
	@(negedge aclk);
	penable = 1'b1;
	@(negedge aclk);
	while (!pready) begin
		@(negedge aclk);
		t++;
		if (t > TIMEOUT) stop_on_timeout("APB pready");
	end
	rdata = prdata;
	err = pslverr;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

// Known offsets never raise pslverr
task automatic write_register(input logic [7:0] addr, input logic [31:0] wdata);
	logic [31:0] rdata;
	logic err;
	apb_access(1'b1, addr, wdata, rdata, err);
	checker_i.check_value("pslverr", 32'h0, {31'h0, err});
endtask

task automatic send_request(input logic [31:0] vaddr, input logic [15:0] len,
		input logic [3:0] pid, input logic [3:0] dest, input logic ctl);
	int t;
	t = 0;
	@(negedge aclk);
	req_valid = 1'b1;
	req_vaddr = vaddr;
	req_len = len;
	req_pid = pid;
	req_dest = dest;
	req_ctl = ctl;
	while (!req_ready) begin
		@(negedge aclk);
		t++;
		if (t > TIMEOUT) stop_on_timeout("req_ready");
	end
	// Taken at the rising edge in between
	@(negedge aclk);
	req_valid = 1'b0;
endtask

task automatic wait_drained();
	int t;
	t = 0;
	@(negedge aclk);
	while (checker_i.pieces_left() != 0 || !req_ready) begin
		@(negedge aclk);
		t++;
		if (t > TIMEOUT) stop_on_timeout("the expected DMA pieces");
	end
endtask

task automatic check_fault(input logic [31:0] vaddr, input logic [15:0] len,
		input logic [3:0] pid);
	int t;
	logic [31:0] rdata;
	logic err;
	t = 0;
	while (!pfault_irq) begin
		@(negedge aclk);
		t++;
		if (t > TIMEOUT) stop_on_timeout("pfault_irq");
	end
	apb_access(1'b0, 8'h0C, 32'h0, rdata, err);
	checker_i.check_value("fault vaddr", vaddr, rdata);
	// Pending bit 31, pid at 19:16, len at 15:0
	apb_access(1'b0, 8'h10, 32'h0, rdata, err);
	checker_i.check_value("fault info", {1'b1, 11'h0, pid, len}, rdata);
endtask

// ----------------------------------------
// Record player
// ----------------------------------------
initial begin
	integer fd;
	integer code;
	integer t;
	string line;
	string name;
	byte kch;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] c;
	logic [31:0] d;
	logic [31:0] e;
	logic [31:0] rdata;
	logic err;
	logic test_open;

	seed = 32'hfc0ff257;
	stall_en = 1'b0;
	lock_q = 1'b0;
	dma_ready = 1'b1;
	mutex_owner = 1'b1;
	mutex_busy = 1'b1;
	req_valid = 1'b0;
	req_vaddr = '0;
	req_len = '0;
	req_pid = '0;
	req_dest = '0;
	req_ctl = 1'b0;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
	paddr = '0;
	pwdata = '0;
	test_open = 1'b0;

	fd = $fopen("test/tlb_input.txt", "r");
	if (fd == 0) begin
		checker_i.report_error("Could not open the stimulus file test/tlb_input.txt");
	end

	t = 0;
	@(negedge aclk);
	while (!aresetn) begin
		@(negedge aclk);
		t++;
		if (t > TIMEOUT) stop_on_timeout("reset release");
	end

	// Idle outputs after reset
	checker_i.begin_test("reset_state");
	checker_i.check_value("ready valid lock unlock irq", 32'h10,
		{27'h0, req_ready, dma_valid, lock, unlock, pfault_irq});
	checker_i.end_test();

	while (fd != 0 && !$feof(fd)) begin
		line = "";
		code = $fgets(line, fd);
		kch = 8'h0;
		code = $sscanf(line, "%c", kch);
		case (kch)
			"T": begin
				code = $sscanf(line, "%c %s", kch, name);
				if (test_open) checker_i.end_test();
				checker_i.begin_test(name);
				test_open = 1'b1;
			end
			"F": begin
				code = $sscanf(line, "%c %h %h %h", kch, a, b, c);
				write_register(8'h00, a);
				write_register(8'h04, b);
				write_register(8'h08, c);
			end
			"R": begin
				code = $sscanf(line, "%c %h %h %h %h %h", kch, a, b, c, d, e);
				send_request(a, b[15:0], c[3:0], d[3:0], e[0]);
			end
			"D": begin
				code = $sscanf(line, "%c %h %h %h %h %h", kch, a, b, c, d, e);
				checker_i.expect_piece(a, b[15:0], c[3:0], d[3:0], e[0]);
			end
			"P": begin
				code = $sscanf(line, "%c %h %h %h", kch, a, b, c);
				check_fault(a, b[15:0], c[3:0]);
			end
			"S": begin
				write_register(8'h14, 32'h0);
				// Restart clears the pending fault
				checker_i.check_value("pfault_irq", 32'h0, {31'h0, pfault_irq});
			end
			"E": begin
				code = $sscanf(line, "%c %h", kch, a);
				apb_access(1'b0, a[7:0], 32'h0, rdata, err);
				checker_i.check_value("pslverr", 32'h1, {31'h0, err});
			end
			"W": wait_drained();
			"Z": begin
				code = $sscanf(line, "%c %h", kch, a);
				stall_en = a[0];
			end
			default: ;
		endcase
	end
	if (fd != 0) $fclose(fd);

	// Quiet tail to catch stray pieces
	stall_en = 1'b0;
	repeat (20) @(negedge aclk);
	if (checker_i.pieces_left() != 0) begin
		checker_i.report_error("Expected DMA pieces never arrived");
	end
	if (test_open) checker_i.end_test();
	checker_i.print_counts();
	if (checker_i.error_count() == 0) begin
		$display("Done: no errors");
	end else begin
		$display("Done: errors found");
	end
	$finish;
end

endmodule

/* list.f */
logic/tlb_pkg.sv
logic/tlb_ifs.sv
logic/tlb_apb_regs.sv
logic/tlb_table.sv
logic/tlb_walk_fsm.sv
logic/tlb_translate_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the translation engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f list.f --top-module tb_top -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Done: no errors"; then
	exit 0
fi
exit 1

/* test/tlb_input.txt */
# T name | F vaddr ppage cmd(large<<8|pid) | R vaddr len pid dest ctl | D paddr len pid dest ctl
# P vaddr len pid (fault) | S restart | E offset (pslverr) | W drain | Z stall on/off
T small_hit
F 00012000 0ABCD000 003
R 00012345 0100 3 5 1
D 0ABCD345 0100 3 5 1
W
T small_split
F 00013000 02220000 003
R 00012F00 0300 3 2 1
D 0ABCDF00 0100 3 2 0
D 02220000 0200 3 2 1
W
T large_wins
F 00040000 12300000 107
F 00045000 05555000 007
R 00045010 0020 7 1 0
D 12305010 0020 7 1 0
W
T miss_restart
R 00013F80 0100 3 4 1
D 02220F80 0080 3 4 0
P 00014000 0080 3
F 00014000 06666000 003
S
D 06666000 0080 3 4 1
W
T dma_stalls
Z 1
R 00012E00 1400 3 6 1
D 0ABCDE00 0200 3 6 0
D 02220000 1000 3 6 0
D 06666000 0200 3 6 1
W
Z 0
T zero_len_and_apb_error
R 00012000 0000 3 0 1
W
E 18
